// ==== nird_defs.svh ====
`ifndef NIRD_DEFS_SVH
`define NIRD_DEFS_SVH

// Pixel and window geometry.
`define NIRD_PIX_W      8
`define NIRD_WIN        9
`define NIRD_R_OUT      4
`define NIRD_R_IN       3

// NI threshold scaling, one per window pixel.
`define NIRD_GAIN       81
`define NIRD_SUM_W      15

// riu2 code.
`define NIRD_CODE_W     4
`define NIRD_NONUNIFORM 9

// Default frame size.
`define NIRD_DEF_COLS   16
`define NIRD_DEF_ROWS   12

`endif

// ==== nird_pkg.sv ====
`include "nird_defs.svh"

package nird_pkg;

    typedef logic [`NIRD_PIX_W-1:0] pixel_t;

    // Bit k holds the sample at angle 45*k.
    typedef logic [7:0] pattern_t;

    typedef logic [`NIRD_CODE_W-1:0] code_t;

    typedef logic [`NIRD_SUM_W-1:0] sum_t;

    // Index 0 is the top row, which is the oldest line.
    typedef pixel_t [`NIRD_WIN-1:0] column_t;

    typedef pixel_t [7:0] ring_t;  // Indexed by angle.

    typedef struct packed {
        pattern_t ni;
        pattern_t rd;
    } patterns_t;

    typedef struct packed {
        code_t ni;
        code_t rd;
    } codes_t;

endpackage

// ==== line_buffer.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module line_buffer import nird_pkg::*; #(
    parameter int COLS = `NIRD_DEF_COLS
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  pixel_t  pix_i,
    input  logic    pix_valid_i,
    output column_t col_o,
    output logic    col_valid_o
);

    localparam int LINES = `NIRD_WIN - 1;
    localparam int PW    = $clog2(COLS);

    // Line k holds the row that is k+1 lines older than the incoming one.
    pixel_t         line_mem [LINES][COLS];
    logic [PW-1:0]  wr_ptr;

    always_ff @(posedge clk) begin
        if (pix_valid_i) begin
            line_mem[0][wr_ptr] <= pix_i;
            for (int k = 1; k < LINES; k++) begin
                line_mem[k][wr_ptr] <= line_mem[k-1][wr_ptr];
            end
            col_o[LINES] <= pix_i;  // Bottom row is the newest pixel.
            for (int k = 0; k < LINES; k++) begin
                col_o[LINES-1-k] <= line_mem[k][wr_ptr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr      <= '0;
            col_valid_o <= 1'b0;
        end else begin
            col_valid_o <= pix_valid_i;
            if (pix_valid_i) begin
                if (wr_ptr == PW'(COLS - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // An unknown strobe would corrupt the pointer and every later frame.
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) !$isunknown(pix_valid_i)
    );

endmodule

// ==== window_9x9.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module window_9x9 import nird_pkg::*; #(
    parameter int COLS = `NIRD_DEF_COLS,
    parameter int ROWS = `NIRD_DEF_ROWS
) (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  column_t                    col_i,
    input  logic                       col_valid_i,
    output column_t [`NIRD_WIN-1:0]    win_o,
    output logic                       win_valid_o,
    output logic                       win_last_o
);

    localparam int EDGE = `NIRD_WIN - 1;
    localparam int CW   = $clog2(COLS);
    localparam int RW   = $clog2(ROWS);

    // Position of the column being shifted in.
    logic [CW-1:0] col_cnt;
    logic [RW-1:0] row_cnt;
    logic          row_end;
    logic          frame_end;
    logic          interior;

    assign row_end   = (col_cnt == CW'(COLS - 1));
    assign frame_end = row_end && (row_cnt == RW'(ROWS - 1));

    // The window is full once eight columns and eight lines precede this pixel.
    assign interior = (col_cnt >= EDGE) && (row_cnt >= EDGE);

    always_ff @(posedge clk) begin
        if (col_valid_i) begin
            for (int c = 0; c < EDGE; c++) begin
                win_o[c] <= win_o[c+1];
            end
            win_o[EDGE] <= col_i;  // Rightmost is the newest column.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            win_valid_o <= 1'b0;
            win_last_o  <= 1'b0;
        end else begin
            win_valid_o <= col_valid_i && interior;
            win_last_o  <= col_valid_i && frame_end;
            if (col_valid_i) begin
                if (row_end) begin
                    col_cnt <= '0;
                    if (frame_end) begin
                        row_cnt <= '0;  // Wrap for the next frame.
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    a_last_is_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) win_last_o |-> win_valid_o
    );

endmodule

// ==== ring_compare.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module ring_compare import nird_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  column_t [`NIRD_WIN-1:0]    win_i,
    input  logic                       win_valid_i,
    input  logic                       win_last_i,
    output patterns_t                  patterns_o,
    output logic                       pat_valid_o,
    output logic                       pat_last_o
);

    localparam int C  = `NIRD_WIN / 2;
    localparam int RO = `NIRD_R_OUT;
    localparam int RI = `NIRD_R_IN;
    // Nearest integer of r/sqrt(2) with 181/256 close to 0.7071.
    localparam int DO = (RO * 181 + 128) / 256;
    localparam int DI = (RI * 181 + 128) / 256;

    ring_t    outer;
    ring_t    inner;
    sum_t     win_sum;
    pattern_t rd_bits;
    pattern_t ni_bits;

    // Samples go counter-clockwise from 0 deg in a window indexed [col][row].
    function automatic ring_t ring_at(input column_t [`NIRD_WIN-1:0] w,
                                      input int r,
                                      input int d);
        ring_t ring;
        ring[0] = w[C+r][C];
        ring[1] = w[C+d][C-d];
        ring[2] = w[C][C-r];
        ring[3] = w[C-d][C-d];
        ring[4] = w[C-r][C];
        ring[5] = w[C-d][C+d];
        ring[6] = w[C][C+r];
        ring[7] = w[C+d][C+d];
        return ring;
    endfunction

    assign outer = ring_at(win_i, RO, DO);
    assign inner = ring_at(win_i, RI, DI);

    always_comb begin
        sum_t acc;
        acc = '0;
        for (int c = 0; c < `NIRD_WIN; c++) begin
            for (int r = 0; r < `NIRD_WIN; r++) begin
                acc = acc + sum_t'(win_i[c][r]);
            end
        end
        win_sum = acc;
    end

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            rd_bits[k] = (outer[k] >= inner[k]);
            // Scaled sample against the sum avoids a divide for the mean.
            ni_bits[k] = (sum_t'(`NIRD_GAIN) * sum_t'(outer[k]) >= win_sum);
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid_i) begin
            patterns_o.rd <= rd_bits;
            patterns_o.ni <= ni_bits;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pat_valid_o <= 1'b0;
            pat_last_o  <= 1'b0;
        end else begin
            pat_valid_o <= win_valid_i;
            pat_last_o  <= win_last_i;
        end
    end

    a_last_is_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) pat_last_o |-> pat_valid_o
    );

endmodule

// ==== riu2_map.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module riu2_map import nird_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  pattern_t pattern_i,
    input  logic     valid_i,
    input  logic     last_i,
    output code_t    code_o,
    output logic     valid_o,
    output logic     last_o
);

    logic [3:0] ones;
    logic [3:0] trans;

    assign ones  = 4'($countones(pattern_i));
    // Compare each bit with its neighbour, wrapping bit 7 to bit 0.
    assign trans = 4'($countones(pattern_i ^ {pattern_i[0], pattern_i[7:1]}));

    always_ff @(posedge clk) begin
        if (valid_i) begin
            code_o <= (trans <= 4'd2) ? code_t'(ones) : code_t'(`NIRD_NONUNIFORM);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            last_o  <= last_i;
        end
    end

    // A valid code must come from a fully known pattern.
    a_code_known: assert property (
        @(posedge clk) disable iff (!rst_n_i) valid_o |-> !$isunknown(code_o)
    );

endmodule

// ==== nird_top.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module nird_top import nird_pkg::*; #(
    parameter int COLS = `NIRD_DEF_COLS,
    parameter int ROWS = `NIRD_DEF_ROWS
) (
    input  logic   clk,
    input  logic   rst_n_i,
    input  pixel_t pix_i,
    input  logic   pix_valid_i,
    output codes_t codes_o,
    output logic   done_o,
    output logic   progress_done_o
);

    column_t                 col;
    logic                    col_valid;
    column_t [`NIRD_WIN-1:0] win;
    logic                    win_valid;
    logic                    win_last;
    patterns_t               patterns;
    logic                    pat_valid;
    logic                    pat_last;
    code_t                   rd_code;
    code_t                   ni_code;

    line_buffer #(.COLS(COLS)) u_line_buffer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pix_i       (pix_i),
        .pix_valid_i (pix_valid_i),
        .col_o       (col),
        .col_valid_o (col_valid)
    );

    window_9x9 #(.COLS(COLS), .ROWS(ROWS)) u_window_9x9 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .col_i       (col),
        .col_valid_i (col_valid),
        .win_o       (win),
        .win_valid_o (win_valid),
        .win_last_o  (win_last)
    );

    ring_compare u_ring_compare (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .win_i       (win),
        .win_valid_i (win_valid),
        .win_last_i  (win_last),
        .patterns_o  (patterns),
        .pat_valid_o (pat_valid),
        .pat_last_o  (pat_last)
    );

    // The RD path carries the stream flags out.
    riu2_map u_riu2_rd (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pattern_i (patterns.rd),
        .valid_i   (pat_valid),
        .last_i    (pat_last),
        .code_o    (rd_code),
        .valid_o   (done_o),
        .last_o    (progress_done_o)
    );

    riu2_map u_riu2_ni (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .pattern_i (patterns.ni),
        .valid_i   (pat_valid),
        .last_i    (pat_last),
        .code_o    (ni_code),
        .valid_o   (),
        .last_o    ()
    );

    assign codes_o = '{ni: ni_code, rd: rd_code};

endmodule

// ==== tb_nird.sv ====
`timescale 1ns/1ps
`include "nird_defs.svh"

module tb_nird import nird_pkg::*; ();

    localparam int COLS    = `NIRD_DEF_COLS;
    localparam int ROWS    = `NIRD_DEF_ROWS;
    localparam int EDGE    = `NIRD_WIN - 1;
    localparam int CODES   = (ROWS - EDGE) * (COLS - EDGE);
    localparam int TIMEOUT = 200;

    // Ring sample positions in the window with index k at angle 45*k.
    localparam int OUT_ROW [8] = '{4, 1, 0, 1, 4, 7, 8, 7};
    localparam int OUT_COL [8] = '{8, 7, 4, 1, 0, 1, 4, 7};
    localparam int IN_ROW  [8] = '{4, 2, 1, 2, 4, 6, 7, 6};
    localparam int IN_COL  [8] = '{7, 6, 4, 2, 1, 2, 4, 6};

    logic        clk;
    logic        rst_n_i;
    pixel_t      pix_i;
    logic        pix_valid_i;
    codes_t      codes_o;
    logic        done_o;
    logic        progress_done_o;

    pixel_t      frame [ROWS][COLS];
    codes_t      exp_codes [$];
    logic        exp_last [$];
    logic [31:0] rng;
    string       test_name;
    int          codes_seen;
    int          codes_in_frame;
    int          lasts_seen;

    nird_top #(.COLS(COLS), .ROWS(ROWS)) u_nird_top (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .pix_i           (pix_i),
        .pix_valid_i     (pix_valid_i),
        .codes_o         (codes_o),
        .done_o          (done_o),
        .progress_done_o (progress_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // At most two circular transitions counts as uniform.
    function automatic code_t uniform_code(input pattern_t p);
        int ones;
        int trans;
        ones  = 0;
        trans = 0;
        for (int k = 0; k < 8; k++) begin
            ones += int'(p[k]);
            if (p[k] != p[(k + 1) % 8]) begin
                trans++;
            end
        end
        return (trans <= 2) ? code_t'(ones) : code_t'(`NIRD_NONUNIFORM);
    endfunction

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_code(input string field, input code_t expected, input code_t actual);
        if (expected !== actual) begin
            fail_stop($sformatf("Fail %s %s code: expected %0d, actual %0d",
                                test_name, field, expected, actual));
        end
    endtask

    task automatic check_last(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            fail_stop($sformatf("Fail %s %s: expected %b, actual %b",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        if (expected != actual) begin
            fail_stop($sformatf("Fail %s %s count: expected %0d, actual %0d",
                                test_name, what, expected, actual));
        end
    endtask

    // Expected codes for every interior centre of the stored frame in raster order.
    task automatic model_frame();
        int        sum;
        int        outer;
        int        inner;
        patterns_t pat;
        codes_t    code;
        for (int y = EDGE; y < ROWS; y++) begin
            for (int x = EDGE; x < COLS; x++) begin
                sum = 0;
                for (int r = 0; r <= EDGE; r++) begin
                    for (int c = 0; c <= EDGE; c++) begin
                        sum += int'(frame[y-EDGE+r][x-EDGE+c]);
                    end
                end
                for (int k = 0; k < 8; k++) begin
                    outer = int'(frame[y-EDGE+OUT_ROW[k]][x-EDGE+OUT_COL[k]]);
                    inner = int'(frame[y-EDGE+IN_ROW[k]][x-EDGE+IN_COL[k]]);
                    pat.rd[k] = (outer >= inner);
                    pat.ni[k] = (`NIRD_GAIN * outer >= sum);
                end
                code.rd = uniform_code(pat.rd);
                code.ni = uniform_code(pat.ni);
                exp_codes.push_back(code);
                exp_last.push_back(y == ROWS - 1 && x == COLS - 1);
            end
        end
    endtask

    task automatic fill_random();
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                rng = xorshift32(rng);
                frame[y][x] = pixel_t'(rng[7:0]);
            end
        end
    endtask

    task automatic drive_frame(input bit gaps);
        int idle;
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                @(negedge clk);
                pix_i       = frame[y][x];
                pix_valid_i = 1'b1;
                rng         = xorshift32(rng);
                idle        = gaps ? int'(rng[1:0]) : 0;
                repeat (idle) begin
                    @(negedge clk);
                    pix_valid_i = 1'b0;
                    pix_i       = pixel_t'(rng[15:8]);  // Junk while idle.
                end
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        codes_seen     = 0;
        codes_in_frame = 0;
        lasts_seen     = 0;
        exp_codes.delete();
        exp_last.delete();
    endtask

    task automatic finish_test(input int codes, input int frames);
        int cycles;
        @(negedge clk);
        pix_valid_i = 1'b0;
        cycles      = 0;
        while (codes_seen < codes) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_stop($sformatf("Timeout in %s: done_o came %0d times, %0d expected",
                                    test_name, codes_seen, codes));
            end
        end
        repeat (8) @(negedge clk);  // Quiet period where any extra code would show.
        check_count("codes", codes, codes_seen);
        check_count("progress pulses", frames, lasts_seen);
        check_count("codes left over", 0, exp_codes.size());
    endtask

    // Outputs settle after the rising edge, so they are read on the falling one.
    always @(negedge clk) begin
        codes_t exp_code;
        logic   exp_l;
        if (rst_n_i && progress_done_o && !done_o) begin
            fail_stop($sformatf("In %s progress_done_o pulsed without done_o", test_name));
        end else if (rst_n_i && done_o) begin
            if (exp_codes.size() == 0) begin
                fail_stop($sformatf("In %s a code arrived when none was expected", test_name));
            end else begin
                exp_code = exp_codes.pop_front();
                exp_l    = exp_last.pop_front();
                check_code("rd", exp_code.rd, codes_o.rd);
                check_code("ni", exp_code.ni, codes_o.ni);
                check_last("progress_done_o", exp_l, progress_done_o);
                codes_seen++;
                codes_in_frame++;
                if (progress_done_o) begin
                    check_count("codes in frame", CODES, codes_in_frame);
                    codes_in_frame = 0;
                    lasts_seen++;
                end
            end
        end
    end

    task automatic test_reset();
        start_test("reset");
        repeat (20) begin
            @(negedge clk);
            check_last("done_o", 1'b0, done_o);
            check_last("progress_done_o", 1'b0, progress_done_o);
        end
    endtask

    task automatic test_flat();
        codes_t code;
        start_test("flat");
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                frame[y][x] = pixel_t'(37);
            end
        end
        code.rd = code_t'(8);  // Every comparison ties, so all bits set.
        code.ni = code_t'(8);
        for (int i = 0; i < CODES; i++) begin
            exp_codes.push_back(code);
            exp_last.push_back(i == CODES - 1);
        end
        drive_frame(1'b0);
        finish_test(CODES, 1);
    endtask

    task automatic test_ramp();
        codes_t code;
        start_test("ramp");
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                frame[y][x] = pixel_t'(x * 10);
            end
        end
        model_frame();
        // Angles 0, 1, 2, 6 and 7 win on a rising ramp.
        for (int i = 0; i < exp_codes.size(); i++) begin
            code         = exp_codes[i];
            code.rd      = code_t'(5);
            exp_codes[i] = code;
        end
        drive_frame(1'b0);
        finish_test(CODES, 1);
    endtask

    task automatic test_random(input string name, input bit gaps);
        start_test(name);
        fill_random();
        model_frame();
        drive_frame(gaps);
        finish_test(CODES, 1);
    endtask

    task automatic test_back_to_back();
        start_test("back_to_back");
        fill_random();
        model_frame();
        drive_frame(1'b0);
        fill_random();
        model_frame();
        drive_frame(1'b0);
        finish_test(2 * CODES, 2);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        pix_i       = '0;
        pix_valid_i = 1'b0;
        rng         = 32'h853d_7160;
        start_test("init");
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;

        test_reset();
        test_flat();
        test_ramp();
        test_random("random_continuous", 1'b0);
        test_random("random_gaps", 1'b1);
        test_back_to_back();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== nird.f ====
+incdir+.
nird_pkg.sv
line_buffer.sv
window_9x9.sv
ring_compare.sv
riu2_map.sv
nird_top.sv
tb_nird.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_nird -f nird.f

result=$(./obj_dir/Vtb_nird || true)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
